/* id_stage.f */
+incdir+rtl
rtl/rv_id_pkg.sv
rtl/id_ex_if.sv
rtl/rv_decoder.sv
rtl/rv_reg_file.sv
rtl/rv_operand_select.sv
rtl/rv_idex_reg.sv
rtl/id_stage.sv
testbench/tb_clock.sv
testbench/id_stage_chk.sv
testbench/id_stage_tb.sv

/* Bender.yml */
package:
  name: id_stage

export_include_dirs:
  - rtl

sources:
  - files:
      - rtl/rv_id_pkg.sv
      - rtl/id_ex_if.sv
      - rtl/rv_decoder.sv
      - rtl/rv_reg_file.sv
      - rtl/rv_operand_select.sv
      - rtl/rv_idex_reg.sv
      - rtl/id_stage.sv
  - target: test
    files:
      - testbench/tb_clock.sv
      - testbench/id_stage_chk.sv
      - testbench/id_stage_tb.sv

/* testbench/id_stage_tb.sv */
`timescale 1ns/1ns
`default_nettype none

`include "rv_id_cfg.svh"

module id_stage_tb import rv_id_pkg::*; ();

	localparam int RESET_CYCLES   = 10;
	localparam int NUM_TESTS      = 6;
	localparam int TEST_CYCLES    = 200;
	localparam int TIMEOUT_CYCLES = RESET_CYCLES + NUM_TESTS * TEST_CYCLES;

	localparam int K_REG    = 0;
	localparam int K_IMM    = 1;
	localparam int K_LUI    = 2;
	localparam int K_AUIPC  = 3;
	localparam int K_BRANCH = 4;
	localparam int K_JAL    = 5;
	localparam int K_JALR   = 6;
	localparam int K_LOAD   = 7;
	localparam int K_STORE  = 8;
	localparam int K_ECALL  = 9;
	localparam int K_EBREAK = 10;
	localparam int K_CSR    = 11;

	localparam logic [2:0] BR_F3 [6]  = '{3'd0, 3'd1, 3'd4, 3'd5, 3'd6, 3'd7};
	localparam logic [2:0] LD_F3 [5]  = '{3'd0, 3'd1, 3'd2, 3'd4, 3'd5};
	localparam logic [2:0] CSR_F3 [6] = '{3'd1, 3'd2, 3'd3, 3'd5, 3'd6, 3'd7};

	typedef struct packed {
		logic [`RV_XLEN-1:0]   port_a;
		logic [`RV_XLEN-1:0]   port_b;
		logic [3:0]            alu_op;
		logic [`RV_REG_AW-1:0] waddr;
		logic                  we;
		logic [5:0]            mem;
		logic                  mem_sel;
		logic                  bad_jump;
		logic                  bad_branch;
		logic                  brk;
		logic                  sys;
		logic [2:0]            csr_op;
		logic                  csr_imm;
		logic [11:0]           csr_addr;
		logic                  exc;
	} ex_t;

	logic                  clk;
	logic                  reset;
	logic                  stall;
	logic                  flush;
	logic                  exc_addr_if;
	logic                  wb_we;
	logic [`RV_REG_AW-1:0] wb_addr;
	logic [`RV_XLEN-1:0]   wb_data;
	logic [`RV_XLEN-1:0]   pc;
	logic [31:0]           instr;
	logic [`RV_XLEN-1:0]   ex_fwd;
	logic [`RV_XLEN-1:0]   mem_fwd;
	logic [`RV_XLEN-1:0]   wb_fwd;
	logic [1:0]            fwd_a_sel;
	logic [1:0]            fwd_b_sel;
	logic                  take_branch;
	logic [`RV_XLEN-1:0]   branch_addr;
	logic [`RV_XLEN-1:0]   jump_addr;
	ex_t                   dut_ex; // EX outputs gathered for comparison

	logic [`RV_XLEN-1:0] shadow [0:`RV_REGS-1];
	logic [31:0]         lfsr = 32'ha188_b343;
	ex_t                 exp_d;
	ex_t                 exp_q;
	logic                exp_take;
	logic [`RV_XLEN-1:0] exp_baddr;
	logic [`RV_XLEN-1:0] exp_jaddr;
	logic                is_branch;
	logic                is_jump;
	int                  checks = 0;
	int                  errors = 0;
	int                  cycles = 0;

	tb_clock #(.PERIOD_NS(100)) clock_inst (.clk_o(clk));

	id_stage id_stage_inst (
		.clk_i            (clk),
		.reset_i          (reset),
		.pc_i             (pc),
		.instr_i          (instr),
		.exc_addr_if_i    (exc_addr_if),
		.wb_data_i        (wb_data),
		.wb_addr_i        (wb_addr),
		.wb_we_i          (wb_we),
		.stall_i          (stall),
		.flush_i          (flush),
		.ex_fwd_i         (ex_fwd),
		.mem_fwd_i        (mem_fwd),
		.wb_fwd_i         (wb_fwd),
		.fwd_a_sel_i      (fwd_a_sel),
		.fwd_b_sel_i      (fwd_b_sel),
		.branch_addr_o    (branch_addr),
		.jump_addr_o      (jump_addr),
		.take_branch_o    (take_branch),
		.ex_port_a_o      (dut_ex.port_a),
		.ex_port_b_o      (dut_ex.port_b),
		.ex_alu_op_o      (dut_ex.alu_op),
		.ex_waddr_o       (dut_ex.waddr),
		.ex_we_o          (dut_ex.we),
		.ex_mem_flags_o   (dut_ex.mem),
		.ex_mem_ex_sel_o  (dut_ex.mem_sel),
		.ex_bad_jump_o    (dut_ex.bad_jump),
		.ex_bad_branch_o  (dut_ex.bad_branch),
		.ex_break_o       (dut_ex.brk),
		.ex_syscall_o     (dut_ex.sys),
		.ex_csr_op_o      (dut_ex.csr_op),
		.ex_csr_imm_o     (dut_ex.csr_imm),
		.ex_csr_addr_o    (dut_ex.csr_addr),
		.ex_exc_addr_if_o (dut_ex.exc)
	);

	// Galois LFSR, x^32 + x^22 + x^2 + x + 1, one step per bit
	function automatic logic [31:0] rand_bits(input int n);
		logic [31:0] r;
		r = '0;
		for (int i = 0; i < n; i++) begin
			lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'h8020_0003) : (lfsr >> 1);
			r = {r[30:0], lfsr[0]};
		end
		return r;
	endfunction

	function automatic int pick_kind(input int mask);
		int kind;
		do
			kind = rand_bits(4);
		while (!mask[kind]);
		return kind;
	endfunction

	function automatic logic [31:0] gen_instr(input int kind);
		logic [4:0]  rd;
		logic [4:0]  rs1;
		logic [4:0]  rs2;
		logic [2:0]  f3;
		logic [11:0] imm;
		logic [19:0] upper;
		logic        alt;
		rd    = rand_bits(5);
		rs1   = rand_bits(5);
		rs2   = rand_bits(5);
		f3    = rand_bits(3);
		imm   = rand_bits(12);
		upper = rand_bits(20);
		alt   = rand_bits(1);
		case (kind)
			K_REG: begin
				alt = alt && (f3 == 3'd0 || f3 == 3'd5); // Only ADD/SUB and SRL/SRA differ
				return {1'b0, alt, 5'b0, rs2, rs1, f3, rd, 7'b0110011};
			end
			K_IMM: begin
				if (f3 == 3'd1)
					imm = {7'b0, imm[4:0]};
				else if (f3 == 3'd5)
					imm = {1'b0, alt, 5'b0, imm[4:0]};
				return {imm, rs1, f3, rd, 7'b0010011};
			end
			K_LUI:    return {upper, rd, 7'b0110111};
			K_AUIPC:  return {upper, rd, 7'b0010111};
			K_BRANCH: begin
				f3 = BR_F3[rand_bits(3) % 6];
				return {imm[11:5], rs2, rs1, f3, imm[4:0], 7'b1100011};
			end
			K_JAL:    return {upper, rd, 7'b1101111};
			K_JALR:   return {imm, rs1, 3'b000, rd, 7'b1100111};
			K_LOAD:   return {imm, rs1, LD_F3[rand_bits(3) % 5], rd, 7'b0000011};
			K_STORE:  begin
				f3 = rand_bits(2) % 3;
				return {imm[11:5], rs2, rs1, f3, imm[4:0], 7'b0100011};
			end
			K_ECALL:  return 32'h0000_0073;
			K_EBREAK: return 32'h0010_0073;
			default:  return {imm, rs1, CSR_F3[rand_bits(3) % 6], rd, 7'b1110011};
		endcase
	endfunction

	function automatic logic [`RV_XLEN-1:0] pick(input logic [1:0] sel, input logic [4:0] r);
		case (sel)
			2'd0:    return shadow[r]; // Entry 0 stays zero
			2'd1:    return ex_fwd;
			2'd2:    return mem_fwd;
			default: return wb_fwd;
		endcase
	endfunction

	function automatic logic [3:0] alu_from_funct(input logic [2:0] f3, input logic alt);
		case (f3)
			3'd0:    return alt ? ALU_SUB : ALU_ADD;
			3'd1:    return ALU_SLL;
			3'd2:    return ALU_SLT;
			3'd3:    return ALU_SLTU;
			3'd4:    return ALU_XOR;
			3'd5:    return alt ? ALU_SRA : ALU_SRL;
			3'd6:    return ALU_OR;
			default: return ALU_AND;
		endcase
	endfunction

	// Expected ID/EX input and combinational outputs for the current inputs
	task automatic predict();
		logic [2:0]          f3;
		logic [4:0]          rs1;
		logic [4:0]          rs2;
		logic [`RV_XLEN-1:0] imm;
		logic [`RV_XLEN-1:0] a;
		logic [`RV_XLEN-1:0] b;
		logic                asel;
		logic                bsel;
		logic                link;
		f3          = instr[14:12];
		rs1         = instr[19:15];
		rs2         = instr[24:20];
		imm         = '0;
		asel        = 1'b0;
		bsel        = 1'b0;
		link        = 1'b0;
		exp_d       = '0;
		exp_d.waddr = instr[11:7];
		exp_take    = 1'b0;
		is_branch   = 1'b0;
		is_jump     = 1'b0;
		case (instr[6:0])
			7'b0110111, 7'b0010111: begin
				rs1          = '0;
				rs2          = '0;
				exp_d.we     = 1'b1;
				bsel         = 1'b1;
				asel         = (instr[6:0] == 7'b0010111);
				exp_d.alu_op = asel ? ALU_ADD : ALU_PASS_B;
				imm          = {instr[31:12], 12'b0};
			end
			7'b1101111: begin
				rs1       = '0;
				rs2       = '0;
				{exp_d.we, asel, link, is_jump} = 4'b1111;
				imm       = {{12{instr[31]}}, instr[19:12], instr[20], instr[30:21], 1'b0};
				exp_jaddr = pc + imm;
			end
			7'b1100111: begin
				rs2       = '0;
				{exp_d.we, asel, link, is_jump} = 4'b1111;
				imm       = {{20{instr[31]}}, instr[31:20]};
				exp_jaddr = (pick(fwd_a_sel, rs1) + imm) & ~32'd1;
			end
			7'b1100011: begin
				exp_d.waddr = '0;
				is_branch   = 1'b1;
				imm         = {{20{instr[31]}}, instr[7], instr[30:25], instr[11:8], 1'b0};
				exp_baddr   = pc + imm;
				a           = pick(fwd_a_sel, rs1);
				b           = pick(fwd_b_sel, rs2);
				case (f3)
					3'd0:    exp_take = (a == b);
					3'd1:    exp_take = (a != b);
					3'd4:    exp_take = ($signed(a) < $signed(b));
					3'd5:    exp_take = ($signed(a) >= $signed(b));
					3'd6:    exp_take = (a < b);
					default: exp_take = (a >= b);
				endcase
				exp_d.bad_branch = (exp_baddr[1:0] != 2'b00);
			end
			7'b0000011: begin
				rs2           = '0;
				exp_d.we      = 1'b1;
				bsel          = 1'b1;
				exp_d.mem_sel = 1'b1;
				exp_d.mem     = {2'b10, f3[1:0] == 2'd0, f3[1:0] == 2'd1, f3[1:0] == 2'd2, f3[2]};
				imm           = {{20{instr[31]}}, instr[31:20]};
			end
			7'b0100011: begin
				exp_d.waddr = '0;
				bsel        = 1'b1;
				exp_d.mem   = {2'b01, f3 == 3'd0, f3 == 3'd1, f3 == 3'd2, 1'b0};
				imm         = {{20{instr[31]}}, instr[31:25], instr[11:7]};
			end
			7'b0010011: begin
				rs2          = '0;
				exp_d.we     = 1'b1;
				bsel         = 1'b1;
				exp_d.alu_op = alu_from_funct(f3, instr[30] && f3 == 3'd5);
				imm          = {{20{instr[31]}}, instr[31:20]};
			end
			7'b0110011: begin
				exp_d.we     = 1'b1;
				exp_d.alu_op = alu_from_funct(f3, instr[30]);
			end
			7'b1110011: begin
				rs2 = '0;
				if (f3 == 3'd0) begin
					rs1         = '0;
					exp_d.waddr = '0;
					exp_d.sys   = (instr[31:20] == 12'h000);
					exp_d.brk   = (instr[31:20] == 12'h001);
				end else begin
					exp_d.we       = 1'b1;
					exp_d.csr_addr = instr[31:20];
					exp_d.csr_imm  = f3[2];
					exp_d.csr_op   = (f3[1:0] == 2'd1) ? CSR_RW :
						(f3[1:0] == 2'd2) ? CSR_RS : CSR_RC;
					if (f3[2]) begin
						rs1  = '0;
						bsel = 1'b1;
						imm  = {27'b0, instr[19:15]};
					end
				end
			end
			default: exp_d.waddr = '0;
		endcase
		exp_d.bad_jump = is_jump && (exp_jaddr[1:0] != 2'b00);
		exp_d.port_a   = asel ? pc : pick(fwd_a_sel, rs1);
		exp_d.port_b   = link ? 32'd4 : (bsel ? imm : pick(fwd_b_sel, rs2));
		exp_d.exc      = exc_addr_if;
	endtask

	task automatic check(input string name, input logic [31:0] got, input logic [31:0] exp);
		checks++;
		assert (got === exp) else begin
			errors++;
			$display("Mismatch %s: got %h, expected %h", name, got, exp);
		end
	endtask

	task automatic check_ex();
		check("ex_port_a_o", dut_ex.port_a, exp_q.port_a);
		check("ex_port_b_o", dut_ex.port_b, exp_q.port_b);
		check("ex_alu_op_o", dut_ex.alu_op, exp_q.alu_op);
		check("ex_waddr_o", dut_ex.waddr, exp_q.waddr);
		check("ex_we_o", dut_ex.we, exp_q.we);
		check("ex_mem_flags_o", dut_ex.mem, exp_q.mem);
		check("ex_mem_ex_sel_o", dut_ex.mem_sel, exp_q.mem_sel);
		check("ex_bad_jump_o", dut_ex.bad_jump, exp_q.bad_jump);
		check("ex_bad_branch_o", dut_ex.bad_branch, exp_q.bad_branch);
		check("ex_break_o", dut_ex.brk, exp_q.brk);
		check("ex_syscall_o", dut_ex.sys, exp_q.sys);
		check("ex_csr_op_o", dut_ex.csr_op, exp_q.csr_op);
		check("ex_csr_imm_o", dut_ex.csr_imm, exp_q.csr_imm);
		check("ex_csr_addr_o", dut_ex.csr_addr, exp_q.csr_addr);
		check("ex_exc_addr_if_o", dut_ex.exc, exp_q.exc);
	endtask

	// Called at a falling edge with the inputs set, returns at the next falling edge
	task automatic issue();
		predict();
		#10;
		check("take_branch_o", take_branch, exp_take);
		if (is_branch)
			check("branch_addr_o", branch_addr, exp_baddr);
		if (is_jump)
			check("jump_addr_o", jump_addr, exp_jaddr);
		@(negedge clk);
		if (reset || flush)
			exp_q = '0;
		else if (!stall)
			exp_q = exp_d;
		if (wb_we && wb_addr != '0)
			shadow[wb_addr] = wb_data; // The read above saw the old value
		check_ex();
	endtask

	task automatic drive_random(input bit rand_fwd, input bit rand_pipe);
		pc = rand_bits(32);
		if (rand_bits(1))
			pc[1:0] = 2'b00;
		exc_addr_if = rand_bits(1);
		wb_we       = rand_bits(1);
		wb_addr     = rand_bits(5);
		wb_data     = rand_bits(32);
		ex_fwd      = rand_bits(32);
		mem_fwd     = rand_bits(32);
		wb_fwd      = rand_bits(32);
		fwd_a_sel   = rand_fwd ? rand_bits(2) : 2'd0;
		fwd_b_sel   = rand_fwd ? rand_bits(2) : 2'd0;
		stall       = rand_pipe ? (rand_bits(2) == 0) : 1'b0;
		flush       = rand_pipe ? (rand_bits(2) == 0) : 1'b0;
	endtask

	task automatic run_test(input int num, input string name, input int n, input int mask,
			input bit rand_fwd, input bit rand_pipe, input bit preload);
		int          err0;
		int          i;
		int          kind;
		logic [31:0] ins;
		err0 = errors;
		if (preload) begin
			for (i = 1; i < `RV_REGS; i++) begin
				drive_random(1'b0, 1'b0);
				wb_we   = 1'b1;
				wb_addr = i;
				instr   = '0;
				issue();
			end
		end
		for (i = 0; i < n; i++) begin
			kind = pick_kind(mask);
			ins  = gen_instr(kind);
			if (kind == K_REG && i % 8 == 0)
				ins[19:15] = '0; // Make sure x0 gets read
			drive_random(rand_fwd, rand_pipe);
			instr = ins;
			issue();
		end
		$display("Test %0d %s: %0d errors", num, name, errors - err0);
	endtask

	always @(posedge clk) begin
		cycles++;
		if (cycles > TIMEOUT_CYCLES) begin
			$display("Timeout: the tests did not finish within %0d cycles", TIMEOUT_CYCLES);
			$display("Regression failed");
			$finish;
		end
	end

	initial begin
		int total;
		for (int r = 0; r < `RV_REGS; r++)
			shadow[r] = '0;
		reset       = 1'b1;
		stall       = 1'b0;
		flush       = 1'b0;
		exc_addr_if = 1'b0;
		wb_we       = 1'b0;
		wb_addr     = '0;
		wb_data     = '0;
		pc          = '0;
		instr       = '0;
		ex_fwd      = '0;
		mem_fwd     = '0;
		wb_fwd      = '0;
		fwd_a_sel   = 2'd0;
		fwd_b_sel   = 2'd0;
		exp_q       = '0;
		repeat (RESET_CYCLES) @(posedge clk);
		@(negedge clk);
		reset = 1'b0;
		check_ex();

		run_test(1, "register file", 60, 1 << K_REG, 1'b0, 1'b0, 1'b1);
		run_test(2, "ALU decode", 50, (1 << K_REG) | (1 << K_IMM) | (1 << K_LUI) |
			(1 << K_AUIPC), 1'b0, 1'b0, 1'b0);
		run_test(3, "forwarding", 50, (1 << K_REG) | (1 << K_BRANCH), 1'b1, 1'b0, 1'b0);
		run_test(4, "branches and jumps", 50, (1 << K_BRANCH) | (1 << K_JAL) | (1 << K_JALR),
			1'b1, 1'b0, 1'b0);
		run_test(5, "pipeline control", 60, 12'hfff, 1'b1, 1'b1, 1'b0);
		run_test(6, "system, memory and CSR", 50, (1 << K_LOAD) | (1 << K_STORE) |
			(1 << K_ECALL) | (1 << K_EBREAK) | (1 << K_CSR), 1'b0, 1'b0, 1'b0);

		total = errors + id_stage_inst.idex_reg_inst.chk_inst.assert_errors;
		$display("Checks %0d, errors %0d, assertion failures %0d", checks, errors,
			id_stage_inst.idex_reg_inst.chk_inst.assert_errors);
		if (total == 0)
			$display("Regression passed");
		else
			$display("Regression failed");
		$finish;
	end

endmodule

`default_nettype wire

/* testbench/id_stage_chk.sv */
`timescale 1ns/1ns
`default_nettype none

`include "rv_id_cfg.svh"

module id_stage_chk #(
	parameter int STATE_W = 2 * `RV_XLEN + 38
) (
	input logic               clk_i,
	input logic               reset_i,
	input logic               stall_i,
	input logic               flush_i,
	input logic               we_i,
	input logic [5:0]         mem_flags_i,
	input logic [STATE_W-1:0] ex_state_i // Every EX output side by side
);

	int assert_errors = 0;

	reset_idle: assert property (@(posedge clk_i) reset_i |=> (!we_i && mem_flags_i == '0))
		else begin
			assert_errors++;
			$error("Write enable or memory flags active after a reset cycle");
		end

	flush_bubble: assert property (@(posedge clk_i) flush_i |=> (ex_state_i == '0))
		else begin
			assert_errors++;
			$error("A flush did not leave an all-zero bubble");
		end

	stall_hold: assert property (@(posedge clk_i)
		(stall_i && !flush_i && !reset_i) |=> $stable(ex_state_i))
		else begin
			assert_errors++;
			$error("EX outputs changed during a stall");
		end

endmodule

bind rv_idex_reg id_stage_chk chk_inst (
	.clk_i       (clk_i),
	.reset_i     (reset_i),
	.stall_i     (stall_i),
	.flush_i     (flush_i),
	.we_i        (ex_we_o),
	.mem_flags_i (ex_mem_flags_o),
	.ex_state_i  ({ex_port_a_o, ex_port_b_o, ex_alu_op_o, ex_waddr_o, ex_we_o,
		ex_mem_flags_o, ex_mem_ex_sel_o, ex_bad_jump_o, ex_bad_branch_o, ex_break_o,
		ex_syscall_o, ex_csr_op_o, ex_csr_imm_o, ex_csr_addr_o, ex_exc_addr_if_o})
);

`default_nettype wire

/* testbench/tb_clock.sv */
`timescale 1ns/1ns
`default_nettype none

module tb_clock #(
	parameter int PERIOD_NS = 100
) (
	output logic clk_o
);

	initial begin
		clk_o = 1'b0;
		forever #(PERIOD_NS / 2) clk_o = ~clk_o;
	end

endmodule

`default_nettype wire

/* rtl/id_stage.sv */
`timescale 1ns/1ns
`default_nettype none

`include "rv_id_cfg.svh"

module id_stage import rv_id_pkg::*; (
	input  logic                  clk_i,
	input  logic                  reset_i,
	input  logic [`RV_XLEN-1:0]   pc_i,
	input  logic [31:0]           instr_i,
	input  logic                  exc_addr_if_i,
	input  logic [`RV_XLEN-1:0]   wb_data_i,
	input  logic [`RV_REG_AW-1:0] wb_addr_i,
	input  logic                  wb_we_i,
	input  logic                  stall_i,
	input  logic                  flush_i,
	input  logic [`RV_XLEN-1:0]   ex_fwd_i,
	input  logic [`RV_XLEN-1:0]   mem_fwd_i,
	input  logic [`RV_XLEN-1:0]   wb_fwd_i,
	input  logic [1:0]            fwd_a_sel_i,
	input  logic [1:0]            fwd_b_sel_i,
	output logic [`RV_XLEN-1:0]   branch_addr_o,
	output logic [`RV_XLEN-1:0]   jump_addr_o,
	output logic                  take_branch_o,
	output logic [`RV_XLEN-1:0]   ex_port_a_o,
	output logic [`RV_XLEN-1:0]   ex_port_b_o,
	output logic [3:0]            ex_alu_op_o,
	output logic [`RV_REG_AW-1:0] ex_waddr_o,
	output logic                  ex_we_o,
	output logic [5:0]            ex_mem_flags_o,
	output logic                  ex_mem_ex_sel_o,
	output logic                  ex_bad_jump_o,
	output logic                  ex_bad_branch_o,
	output logic                  ex_break_o,
	output logic                  ex_syscall_o,
	output logic [2:0]            ex_csr_op_o,
	output logic                  ex_csr_imm_o,
	output logic [11:0]           ex_csr_addr_o,
	output logic                  ex_exc_addr_if_o
);

	id_ctrl_t            ctrl;
	logic [`RV_XLEN-1:0] imm;
	logic [`RV_XLEN-1:0] rdata_a;
	logic [`RV_XLEN-1:0] rdata_b;

	id_ex_if id_ex ();

	rv_decoder decoder_inst (
		.instr_i (instr_i),
		.ctrl_o  (ctrl),
		.imm_o   (imm)
	);

	// Writeback uses the register file write port directly
	rv_reg_file reg_file_inst (
		.clk_i     (clk_i),
		.raddr_a_i (ctrl.rs1),
		.raddr_b_i (ctrl.rs2),
		.rdata_a_o (rdata_a),
		.rdata_b_o (rdata_b),
		.waddr_i   (wb_addr_i),
		.wdata_i   (wb_data_i),
		.we_i      (wb_we_i)
	);

	rv_operand_select operand_select_inst (
		.pc_i          (pc_i),
		.ctrl_i        (ctrl),
		.imm_i         (imm),
		.rdata_a_i     (rdata_a),
		.rdata_b_i     (rdata_b),
		.ex_fwd_i      (ex_fwd_i),
		.mem_fwd_i     (mem_fwd_i),
		.wb_fwd_i      (wb_fwd_i),
		.fwd_a_sel_i   (fwd_a_sel_i),
		.fwd_b_sel_i   (fwd_b_sel_i),
		.exc_addr_if_i (exc_addr_if_i),
		.take_branch_o (take_branch_o),
		.branch_addr_o (branch_addr_o),
		.jump_addr_o   (jump_addr_o),
		.out           (id_ex)
	);

	rv_idex_reg idex_reg_inst (
		.clk_i            (clk_i),
		.reset_i          (reset_i),
		.stall_i          (stall_i),
		.flush_i          (flush_i),
		.in               (id_ex),
		.ex_port_a_o      (ex_port_a_o),
		.ex_port_b_o      (ex_port_b_o),
		.ex_alu_op_o      (ex_alu_op_o),
		.ex_waddr_o       (ex_waddr_o),
		.ex_we_o          (ex_we_o),
		.ex_mem_flags_o   (ex_mem_flags_o),
		.ex_mem_ex_sel_o  (ex_mem_ex_sel_o),
		.ex_bad_jump_o    (ex_bad_jump_o),
		.ex_bad_branch_o  (ex_bad_branch_o),
		.ex_break_o       (ex_break_o),
		.ex_syscall_o     (ex_syscall_o),
		.ex_csr_op_o      (ex_csr_op_o),
		.ex_csr_imm_o     (ex_csr_imm_o),
		.ex_csr_addr_o    (ex_csr_addr_o),
		.ex_exc_addr_if_o (ex_exc_addr_if_o)
	);

endmodule

`default_nettype wire

/* rtl/rv_idex_reg.sv */
`timescale 1ns/1ns
`default_nettype none

`include "rv_id_cfg.svh"

module rv_idex_reg import rv_id_pkg::*; (
	input  logic                  clk_i,
	input  logic                  reset_i,
	input  logic                  stall_i,
	input  logic                  flush_i,
	id_ex_if.dst                  in,
	output logic [`RV_XLEN-1:0]   ex_port_a_o,
	output logic [`RV_XLEN-1:0]   ex_port_b_o,
	output alu_op_e               ex_alu_op_o,
	output logic [`RV_REG_AW-1:0] ex_waddr_o,
	output logic                  ex_we_o,
	output mem_flags_t            ex_mem_flags_o,
	output logic                  ex_mem_ex_sel_o,
	output logic                  ex_bad_jump_o,
	output logic                  ex_bad_branch_o,
	output logic                  ex_break_o,
	output logic                  ex_syscall_o,
	output csr_op_e               ex_csr_op_o,
	output logic                  ex_csr_imm_o,
	output logic [11:0]           ex_csr_addr_o,
	output logic                  ex_exc_addr_if_o
);

	id_ctrl_t            ctrl_q;
	logic [`RV_XLEN-1:0] port_a_q;
	logic [`RV_XLEN-1:0] port_b_q;
	logic                bad_jump_q;
	logic                bad_branch_q;
	logic                exc_addr_if_q;

	always_ff @(posedge clk_i) begin
		if (reset_i || flush_i) begin // A flush loads the same all-zero bubble as reset
			ctrl_q        <= '0;
			port_a_q      <= '0;
			port_b_q      <= '0;
			bad_jump_q    <= 1'b0;
			bad_branch_q  <= 1'b0;
			exc_addr_if_q <= 1'b0;
		end else if (!stall_i) begin
			ctrl_q        <= in.ctrl;
			port_a_q      <= in.port_a;
			port_b_q      <= in.port_b;
			bad_jump_q    <= in.bad_jump;
			bad_branch_q  <= in.bad_branch;
			exc_addr_if_q <= in.exc_addr_if;
		end
	end

	assign ex_port_a_o      = port_a_q;
	assign ex_port_b_o      = port_b_q;
	assign ex_alu_op_o      = ctrl_q.alu_op;
	assign ex_waddr_o       = ctrl_q.rd;
	assign ex_we_o          = ctrl_q.we;
	assign ex_mem_flags_o   = ctrl_q.mem;
	assign ex_mem_ex_sel_o  = ctrl_q.mem_ex_sel;
	assign ex_bad_jump_o    = bad_jump_q;
	assign ex_bad_branch_o  = bad_branch_q;
	assign ex_break_o       = ctrl_q.break_op;
	assign ex_syscall_o     = ctrl_q.syscall_op;
	assign ex_csr_op_o      = ctrl_q.csr_op;
	assign ex_csr_imm_o     = ctrl_q.csr_imm;
	assign ex_csr_addr_o    = ctrl_q.csr_addr;
	assign ex_exc_addr_if_o = exc_addr_if_q;

endmodule

`default_nettype wire

/* rtl/rv_operand_select.sv */
`timescale 1ns/1ns
`default_nettype none

`include "rv_id_cfg.svh"

module rv_operand_select import rv_id_pkg::*; (
	input  logic [`RV_XLEN-1:0] pc_i,
	input  id_ctrl_t            ctrl_i,
	input  logic [`RV_XLEN-1:0] imm_i,
	input  logic [`RV_XLEN-1:0] rdata_a_i,
	input  logic [`RV_XLEN-1:0] rdata_b_i,
	input  logic [`RV_XLEN-1:0] ex_fwd_i,
	input  logic [`RV_XLEN-1:0] mem_fwd_i,
	input  logic [`RV_XLEN-1:0] wb_fwd_i,
	input  logic [1:0]          fwd_a_sel_i,
	input  logic [1:0]          fwd_b_sel_i,
	input  logic                exc_addr_if_i,
	output logic                take_branch_o,
	output logic [`RV_XLEN-1:0] branch_addr_o,
	output logic [`RV_XLEN-1:0] jump_addr_o,
	id_ex_if.src                out
);

	localparam logic [`RV_XLEN-1:0] LINK_OFFSET = 4;

	logic [`RV_XLEN-1:0] fwd_a;
	logic [`RV_XLEN-1:0] fwd_b;
	logic [`RV_XLEN-1:0] jalr_sum;

	function automatic logic [`RV_XLEN-1:0] fwd_mux(
		input logic [1:0]          sel,
		input logic [`RV_XLEN-1:0] rf,
		input logic [`RV_XLEN-1:0] ex,
		input logic [`RV_XLEN-1:0] mem,
		input logic [`RV_XLEN-1:0] wb
	);
		case (sel)
			2'd0:    return rf;
			2'd1:    return ex;
			2'd2:    return mem;
			default: return wb;
		endcase
	endfunction

	assign fwd_a = fwd_mux(fwd_a_sel_i, rdata_a_i, ex_fwd_i, mem_fwd_i, wb_fwd_i);
	assign fwd_b = fwd_mux(fwd_b_sel_i, rdata_b_i, ex_fwd_i, mem_fwd_i, wb_fwd_i);

	// Branches resolve here so fetch can redirect without waiting for EX
	always_comb begin
		case (ctrl_i.cmp_op)
			CMP_EQ:  take_branch_o = (fwd_a == fwd_b);
			CMP_NE:  take_branch_o = (fwd_a != fwd_b);
			CMP_LT:  take_branch_o = ($signed(fwd_a) < $signed(fwd_b));
			CMP_GE:  take_branch_o = ($signed(fwd_a) >= $signed(fwd_b));
			CMP_LTU: take_branch_o = (fwd_a < fwd_b);
			CMP_GEU: take_branch_o = (fwd_a >= fwd_b);
			default: take_branch_o = 1'b0;
		endcase
	end

	assign jalr_sum      = fwd_a + imm_i;
	assign branch_addr_o = pc_i + imm_i;
	assign jump_addr_o   = ctrl_i.jalr ? {jalr_sum[`RV_XLEN-1:1], 1'b0} : pc_i + imm_i;

	assign out.ctrl        = ctrl_i;
	assign out.port_a      = ctrl_i.porta_sel ? pc_i : fwd_a;
	assign out.port_b      = ctrl_i.link ? LINK_OFFSET : (ctrl_i.portb_sel ? imm_i : fwd_b);
	assign out.bad_jump    = ctrl_i.jump && (jump_addr_o[1:0] != 2'b00);
	assign out.bad_branch  = (ctrl_i.cmp_op != CMP_NONE) && (branch_addr_o[1:0] != 2'b00);
	assign out.exc_addr_if = exc_addr_if_i;

endmodule

`default_nettype wire

/* rtl/rv_reg_file.sv */
`timescale 1ns/1ns
`default_nettype none

`include "rv_id_cfg.svh"

module rv_reg_file (
	input  logic                  clk_i,
	input  logic [`RV_REG_AW-1:0] raddr_a_i,
	input  logic [`RV_REG_AW-1:0] raddr_b_i,
	output logic [`RV_XLEN-1:0]   rdata_a_o,
	output logic [`RV_XLEN-1:0]   rdata_b_o,
	input  logic [`RV_REG_AW-1:0] waddr_i,
	input  logic [`RV_XLEN-1:0]   wdata_i,
	input  logic                  we_i
);

	// Register 0 has no storage
	logic [`RV_XLEN-1:0] regs [1:`RV_REGS-1];

	always_ff @(posedge clk_i) begin
		if (we_i && (waddr_i != '0)) begin
			regs[waddr_i] <= wdata_i;
		end
	end

	// A read in the write cycle still sees the old value
	assign rdata_a_o = (raddr_a_i == '0) ? '0 : regs[raddr_a_i];
	assign rdata_b_o = (raddr_b_i == '0) ? '0 : regs[raddr_b_i];

endmodule

`default_nettype wire

/* rtl/rv_decoder.sv */
`timescale 1ns/1ns
`default_nettype none

`include "rv_id_cfg.svh"

module rv_decoder import rv_id_pkg::*; (
	input  logic [31:0]         instr_i,
	output id_ctrl_t            ctrl_o,
	output logic [`RV_XLEN-1:0] imm_o
);

	localparam logic [6:0] OP_LUI    = 7'b0110111;
	localparam logic [6:0] OP_AUIPC  = 7'b0010111;
	localparam logic [6:0] OP_JAL    = 7'b1101111;
	localparam logic [6:0] OP_JALR   = 7'b1100111;
	localparam logic [6:0] OP_BRANCH = 7'b1100011;
	localparam logic [6:0] OP_LOAD   = 7'b0000011;
	localparam logic [6:0] OP_STORE  = 7'b0100011;
	localparam logic [6:0] OP_IMM    = 7'b0010011;
	localparam logic [6:0] OP_REG    = 7'b0110011;
	localparam logic [6:0] OP_SYSTEM = 7'b1110011;

	logic [6:0]          opcode;
	logic [2:0]          funct3;
	logic                alt;     // funct7 bit 5 selects SUB and SRA
	logic                valid;
	logic [`RV_XLEN-1:0] imm_i;
	logic [`RV_XLEN-1:0] imm_s;
	logic [`RV_XLEN-1:0] imm_b;
	logic [`RV_XLEN-1:0] imm_u;
	logic [`RV_XLEN-1:0] imm_j;

	assign opcode = instr_i[6:0];
	assign funct3 = instr_i[14:12];
	assign alt    = instr_i[30];

	assign imm_i = {{(`RV_XLEN-12){instr_i[31]}}, instr_i[31:20]};
	assign imm_s = {{(`RV_XLEN-12){instr_i[31]}}, instr_i[31:25], instr_i[11:7]};
	assign imm_b = {{(`RV_XLEN-12){instr_i[31]}}, instr_i[7], instr_i[30:25],
		instr_i[11:8], 1'b0};
	assign imm_u = {instr_i[31:12], 12'b0};
	assign imm_j = {{(`RV_XLEN-20){instr_i[31]}}, instr_i[19:12], instr_i[20],
		instr_i[30:21], 1'b0};

	function automatic alu_op_e alu_decode(input logic [2:0] f3, input logic sub_sra);
		case (f3)
			3'b000:  return sub_sra ? ALU_SUB : ALU_ADD;
			3'b001:  return ALU_SLL;
			3'b010:  return ALU_SLT;
			3'b011:  return ALU_SLTU;
			3'b100:  return ALU_XOR;
			3'b101:  return sub_sra ? ALU_SRA : ALU_SRL;
			3'b110:  return ALU_OR;
			default: return ALU_AND;
		endcase
	endfunction

	always_comb begin
		ctrl_o     = '0;
		imm_o      = '0;
		valid      = 1'b1;
		ctrl_o.rs1 = instr_i[19:15];
		ctrl_o.rs2 = instr_i[24:20];
		ctrl_o.rd  = instr_i[11:7];

		case (opcode)
			OP_LUI, OP_AUIPC: begin
				ctrl_o.rs1       = '0;
				ctrl_o.rs2       = '0;
				ctrl_o.we        = 1'b1;
				ctrl_o.portb_sel = 1'b1;
				ctrl_o.porta_sel = (opcode == OP_AUIPC);
				ctrl_o.alu_op    = (opcode == OP_LUI) ? ALU_PASS_B : ALU_ADD;
				imm_o            = imm_u;
			end
			OP_JAL, OP_JALR: begin
				ctrl_o.rs2       = '0;
				ctrl_o.we        = 1'b1;
				ctrl_o.porta_sel = 1'b1;
				ctrl_o.link      = 1'b1;
				ctrl_o.jump      = 1'b1;
				ctrl_o.jalr      = (opcode == OP_JALR);
				if (opcode == OP_JAL) begin
					ctrl_o.rs1 = '0;
					imm_o      = imm_j;
				end else begin
					imm_o = imm_i;
				end
			end
			OP_BRANCH: begin
				ctrl_o.rd = '0;
				imm_o     = imm_b;
				case (funct3)
					3'b000:  ctrl_o.cmp_op = CMP_EQ;
					3'b001:  ctrl_o.cmp_op = CMP_NE;
					3'b100:  ctrl_o.cmp_op = CMP_LT;
					3'b101:  ctrl_o.cmp_op = CMP_GE;
					3'b110:  ctrl_o.cmp_op = CMP_LTU;
					3'b111:  ctrl_o.cmp_op = CMP_GEU;
					default: valid = 1'b0;
				endcase
			end
			OP_LOAD: begin
				ctrl_o.rs2             = '0;
				ctrl_o.we              = 1'b1;
				ctrl_o.portb_sel       = 1'b1;
				ctrl_o.mem_ex_sel      = 1'b1;
				ctrl_o.mem.read        = 1'b1;
				ctrl_o.mem.unsigned_op = funct3[2];
				imm_o                  = imm_i;
				case (funct3)
					3'b000, 3'b100: ctrl_o.mem.byte_op = 1'b1;
					3'b001, 3'b101: ctrl_o.mem.half_op = 1'b1;
					3'b010:         ctrl_o.mem.word_op = 1'b1;
					default:        valid = 1'b0;
				endcase
			end
			OP_STORE: begin
				ctrl_o.rd        = '0;
				ctrl_o.portb_sel = 1'b1;
				ctrl_o.mem.write = 1'b1;
				imm_o            = imm_s;
				case (funct3)
					3'b000:  ctrl_o.mem.byte_op = 1'b1;
					3'b001:  ctrl_o.mem.half_op = 1'b1;
					3'b010:  ctrl_o.mem.word_op = 1'b1;
					default: valid = 1'b0;
				endcase
			end
			OP_IMM: begin
				ctrl_o.rs2       = '0;
				ctrl_o.we        = 1'b1;
				ctrl_o.portb_sel = 1'b1;
				ctrl_o.alu_op    = alu_decode(funct3, alt && (funct3 == 3'b101));
				imm_o            = imm_i;
			end
			OP_REG: begin
				ctrl_o.we     = 1'b1;
				ctrl_o.alu_op = alu_decode(funct3, alt);
			end
			OP_SYSTEM: begin
				ctrl_o.rs2 = '0;
				if (funct3 == 3'b000) begin
					ctrl_o.rs1        = '0;
					ctrl_o.rd         = '0;
					ctrl_o.syscall_op = (instr_i[31:20] == 12'h000);
					ctrl_o.break_op   = (instr_i[31:20] == 12'h001);
					valid             = ctrl_o.syscall_op || ctrl_o.break_op;
				end else begin
					ctrl_o.we       = 1'b1;
					ctrl_o.csr_addr = instr_i[31:20];
					ctrl_o.csr_imm  = funct3[2];
					case (funct3[1:0])
						2'b01:   ctrl_o.csr_op = CSR_RW;
						2'b10:   ctrl_o.csr_op = CSR_RS;
						2'b11:   ctrl_o.csr_op = CSR_RC;
						default: valid = 1'b0;
					endcase
					if (funct3[2]) begin // The rs1 field is the 5-bit zimm here
						ctrl_o.rs1       = '0;
						ctrl_o.portb_sel = 1'b1;
						imm_o            = {{(`RV_XLEN-5){1'b0}}, instr_i[19:15]};
					end
				end
			end
			default: valid = 1'b0;
		endcase

		if (!valid) begin
			ctrl_o = '0;
			imm_o  = '0;
		end
	end

endmodule

`default_nettype wire

/* rtl/id_ex_if.sv */
`timescale 1ns/1ns
`default_nettype none

`include "rv_id_cfg.svh"

// Decoded operands and control on their way into the ID/EX register
interface id_ex_if import rv_id_pkg::*; ();

	id_ctrl_t            ctrl;
	logic [`RV_XLEN-1:0] port_a;
	logic [`RV_XLEN-1:0] port_b;
	logic                bad_jump;
	logic                bad_branch;
	logic                exc_addr_if; // Fetch fault that travels with the instruction

	modport src (
		output ctrl,
		output port_a,
		output port_b,
		output bad_jump,
		output bad_branch,
		output exc_addr_if
	);

	modport dst (
		input ctrl,
		input port_a,
		input port_b,
		input bad_jump,
		input bad_branch,
		input exc_addr_if
	);

endinterface

`default_nettype wire

/* rtl/rv_id_pkg.sv */
`default_nettype none

`include "rv_id_cfg.svh"

package rv_id_pkg;

	typedef enum logic [3:0] {
		ALU_ADD,
		ALU_SUB,
		ALU_SLL,
		ALU_SLT,
		ALU_SLTU,
		ALU_XOR,
		ALU_SRL,
		ALU_SRA,
		ALU_OR,
		ALU_AND,
		ALU_PASS_B // LUI sends the immediate straight through
	} alu_op_e;

	typedef enum logic [2:0] {
		CMP_NONE,
		CMP_EQ,
		CMP_NE,
		CMP_LT,
		CMP_GE,
		CMP_LTU,
		CMP_GEU
	} cmp_op_e;

	typedef enum logic [2:0] {
		CSR_NONE,
		CSR_RW,
		CSR_RS,
		CSR_RC
	} csr_op_e;

	typedef struct packed {
		logic read;
		logic write;
		logic byte_op;
		logic half_op;
		logic word_op;
		logic unsigned_op; // Zero extension on loads
	} mem_flags_t;

	// An all-zero value is a bubble
	typedef struct packed {
		logic [`RV_REG_AW-1:0] rs1;
		logic [`RV_REG_AW-1:0] rs2;
		logic [`RV_REG_AW-1:0] rd;
		logic                  we;
		alu_op_e               alu_op;
		cmp_op_e               cmp_op;
		mem_flags_t            mem;
		logic                  mem_ex_sel; // Writeback takes the memory result
		logic                  porta_sel;  // Port A carries the PC
		logic                  portb_sel;  // Port B carries the immediate
		logic                  jump;
		logic                  jalr;
		logic                  link;       // Port B carries 4 for the return address
		logic                  break_op;
		logic                  syscall_op;
		csr_op_e               csr_op;
		logic                  csr_imm;
		logic [11:0]           csr_addr;
	} id_ctrl_t;

endpackage

`default_nettype wire

/* rtl/rv_id_cfg.svh */
`ifndef RV_ID_CFG_SVH
`define RV_ID_CFG_SVH

// Data and address width
`define RV_XLEN 32

// Architectural register count and the address width that indexes it
`define RV_REGS 32
`define RV_REG_AW 5

`endif
